/* src/rv_types_pkg.sv */
// Datapath width types
package rv_types_pkg;

    localparam int XLEN = 32;

    // Operand, result and pc word
    typedef logic [XLEN-1:0] xlen_t;

    // Register file index
    typedef logic [4:0] reg_addr_t;

    // CSR address field
    typedef logic [11:0] csr_addr_t;

    // Redirect target, bit 0 is always zero
    typedef logic [XLEN-1:1] pc_target_t;

    // Decode compare results as {lt, ltu, eq}
    typedef logic [2:0] cmp_flags_t;

    localparam int CMP_LT  = 2;
    localparam int CMP_LTU = 1;
    localparam int CMP_EQ  = 0;

endpackage

/* src/exec_uop_pkg.sv */
// Execute stage operation encodings
package exec_uop_pkg;

    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_MUL  = 2'd2,
        UNIT_CSR  = 2'd3
    } unit_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10      // LUI style move
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL    = 2'd0,
        MULH   = 2'd1,
        MULHSU = 2'd2,
        MULHU  = 2'd3
    } mul_op_e;

    typedef enum logic [2:0] {
        CSR_NONE = 3'd0,
        CSRRW    = 3'd1,
        CSRRS    = 3'd2,
        CSRRC    = 3'd3,
        ECALL    = 3'd4,
        EBREAK   = 3'd5
    } csr_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BEQ     = 3'd1,
        BNE     = 3'd2,
        BLT     = 3'd3,
        BGE     = 3'd4,
        BLTU    = 3'd5,
        BGEU    = 3'd6
    } br_cond_e;

    typedef enum logic [1:0] {
        KIND_OTHER  = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JUMP   = 2'd2
    } instr_kind_e;

    typedef enum logic [1:0] {
        WB_RESULT  = 2'd0,
        WB_PC_PLUS = 2'd1,
        WB_MUL     = 2'd2
    } wb_sel_e;

    // Machine CSR addresses
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MCYCLE   = 12'hB00;

    localparam logic [31:0] CAUSE_ECALL  = 32'd11;
    localparam logic [31:0] CAUSE_EBREAK = 32'd3;

    // Cycles from a sampled request to the acknowledge
    localparam int MUL_LATENCY = 3;

endpackage

/* src/alu.sv */
// Integer ALU
`timescale 1ns/1ps

module alu
    import rv_types_pkg::*;
    import exec_uop_pkg::*;
(
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    input  alu_op_e op_i,
    output xlen_t   result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;            // Also the branch and jump target
            SUB:     result_o = a_i - b_i;
            SLL:     result_o = a_i << shamt;
            SLT:     result_o = xlen_t'(lt_signed);
            SLTU:    result_o = xlen_t'(lt_unsigned);
            XOR:     result_o = a_i ^ b_i;
            SRL:     result_o = a_i >> shamt;
            SRA:     result_o = xlen_t'($signed(a_i) >>> shamt);
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            PASS_B:  result_o = b_i;
            default: result_o = '0;
        endcase
    end

endmodule

/* src/mul_unit.sv */
// Multi-cycle multiplier
`timescale 1ns/1ps

module mul_unit
    import rv_types_pkg::*;
    import exec_uop_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    req_i,
    input  mul_op_e op_i,
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    output logic    ack_o,
    output xlen_t   result_o
);

    localparam int CNT_W = $clog2(MUL_LATENCY + 1);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

    mul_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    mul_op_e          op_q;
    xlen_t            a_q;
    xlen_t            b_q;
    xlen_t            result_q;

    logic               sign_a;
    logic               sign_b;
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] prod;

    // Only MULHU treats rs1 as unsigned
    assign sign_a = (op_q != MULHU);
    assign sign_b = (op_q == MUL) || (op_q == MULH);
    assign a_ext  = {sign_a & a_q[31], a_q};
    assign b_ext  = {sign_b & b_q[31], b_q};
    assign prod   = a_ext * b_ext;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (req_i) begin
                        state_q <= MUL_BUSY;
                        cnt_q   <= CNT_W'(MUL_LATENCY - 1);
                    end
                end
                MUL_BUSY: begin
                    if (cnt_q == '0) begin
                        state_q <= MUL_DONE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                MUL_DONE: begin
                    if (!req_i) begin
                        state_q <= MUL_IDLE;     // Four-phase return to zero
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    // Operand capture and product word
    always_ff @(posedge clk_i) begin
        if (state_q == MUL_IDLE && req_i) begin
            op_q <= op_i;
            a_q  <= a_i;
            b_q  <= b_i;
        end
        if (state_q == MUL_BUSY && cnt_q == '0) begin
            result_q <= (op_q == MUL) ? prod[31:0] : prod[63:32];
        end
    end

    assign ack_o    = (state_q == MUL_DONE);
    assign result_o = result_q;

    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_o) |-> req_i);

    a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        req_i && !ack_o |=> req_i);

endmodule

/* src/csr_unit.sv */
// Machine mode CSR file
`timescale 1ns/1ps

module csr_unit
    import rv_types_pkg::*;
    import exec_uop_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      commit_i,
    input  csr_op_e   op_i,
    input  logic      imm_i,
    input  xlen_t     rs1_i,
    input  logic [4:0] zimm_i,
    input  csr_addr_t addr_i,
    input  xlen_t     pc_i,
    output xlen_t     rdata_o,
    output xlen_t     mtvec_o
);

    xlen_t mscratch_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mcycle_q;

    xlen_t src;
    xlen_t wdata;
    logic  csr_wr;
    logic  trap;

    always_comb begin
        case (addr_i)
            CSR_MSCRATCH: rdata_o = mscratch_q;
            CSR_MTVEC:    rdata_o = mtvec_q;
            CSR_MEPC:     rdata_o = mepc_q;
            CSR_MCAUSE:   rdata_o = mcause_q;
            CSR_MCYCLE:   rdata_o = mcycle_q;
            default:      rdata_o = '0;      // Unimplemented address
        endcase
    end

    assign src = imm_i ? xlen_t'(zimm_i) : rs1_i;

    always_comb begin
        case (op_i)
            CSRRW:   wdata = src;
            CSRRS:   wdata = rdata_o | src;
            CSRRC:   wdata = rdata_o & ~src;
            default: wdata = rdata_o;
        endcase
    end

    assign csr_wr = commit_i && (op_i == CSRRW || op_i == CSRRS || op_i == CSRRC);
    assign trap   = commit_i && (op_i == ECALL || op_i == EBREAK);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mcycle_q   <= '0;
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
            if (csr_wr) begin
                case (addr_i)
                    CSR_MSCRATCH: mscratch_q <= wdata;
                    CSR_MTVEC:    mtvec_q    <= wdata;
                    CSR_MEPC:     mepc_q     <= wdata;
                    CSR_MCAUSE:   mcause_q   <= wdata;
                    CSR_MCYCLE:   mcycle_q   <= wdata;  // Write wins over the count
                    default:      ;
                endcase
            end
            if (trap) begin
                mepc_q   <= pc_i;
                mcause_q <= (op_i == ECALL) ? CAUSE_ECALL : CAUSE_EBREAK;
            end
        end
    end

    assign mtvec_o = mtvec_q;

    a_commit_has_op: assert property (@(posedge clk_i) disable iff (rst_i)
        commit_i |-> op_i != CSR_NONE);

endmodule

/* src/execute_stage.sv */
// Pipeline execute stage
`timescale 1ns/1ps

module execute_stage
    import rv_types_pkg::*;
    import exec_uop_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic        valid_i,
    input  unit_e       unit_i,
    input  alu_op_e     alu_op_i,
    input  mul_op_e     mul_op_i,
    input  csr_op_e     csr_op_i,
    input  logic        csr_imm_i,
    input  br_cond_e    br_cond_i,
    input  instr_kind_e kind_i,
    input  wb_sel_e     wb_sel_i,
    input  logic        we_i,
    input  reg_addr_t   rd_i,
    input  xlen_t       pc_i,
    input  xlen_t       pc_plus_i,
    input  xlen_t       op_a_i,
    input  xlen_t       op_b_i,
    input  cmp_flags_t  cmp_flags_i,

    output logic        stall_o,
    output xlen_t       fwd_data_o,
    output logic        redirect_o,
    output pc_target_t  redirect_pc_o,
    output logic        wb_valid_o,
    output logic        wb_we_o,
    output reg_addr_t   wb_rd_o,
    output xlen_t       wb_data_o
);

    xlen_t alu_result;
    xlen_t csr_rdata;
    xlen_t mtvec;
    xlen_t mul_result;
    xlen_t unit_result;
    logic  mul_req_q;
    logic  mul_ack;
    logic  is_mul;
    logic  mul_done;
    logic  retire;
    logic  br_taken;
    logic  trap;

    alu u_alu (
        .a_i      (op_a_i),
        .b_i      (op_b_i),
        .op_i     (alu_op_i),
        .result_o (alu_result)
    );

    mul_unit u_mul (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (mul_req_q),
        .op_i     (mul_op_i),
        .a_i      (op_a_i),
        .b_i      (op_b_i),
        .ack_o    (mul_ack),
        .result_o (mul_result)
    );

    csr_unit u_csr (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .commit_i (retire && unit_i == UNIT_CSR),
        .op_i     (csr_op_i),
        .imm_i    (csr_imm_i),
        .rs1_i    (op_a_i),
        .zimm_i   (op_b_i[16:12]),
        .addr_i   (op_b_i[11:0]),
        .pc_i     (pc_i),
        .rdata_o  (csr_rdata),
        .mtvec_o  (mtvec)
    );

    assign is_mul   = valid_i && (unit_i == UNIT_MUL);
    assign mul_done = mul_req_q && mul_ack;    // Ignore a stale ack from the previous multiply
    assign stall_o  = is_mul && !mul_done;
    assign retire   = valid_i && !stall_o;

    // Request phase of the handshake
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_req_q <= 1'b0;
        end else if (mul_done) begin
            mul_req_q <= 1'b0;
        end else if (is_mul && !mul_req_q && !mul_ack) begin
            mul_req_q <= 1'b1;
        end
    end

    always_comb begin
        case (br_cond_i)
            BEQ:     br_taken = cmp_flags_i[CMP_EQ];
            BNE:     br_taken = !cmp_flags_i[CMP_EQ];
            BLT:     br_taken = cmp_flags_i[CMP_LT];
            BGE:     br_taken = !cmp_flags_i[CMP_LT];
            BLTU:    br_taken = cmp_flags_i[CMP_LTU];
            BGEU:    br_taken = !cmp_flags_i[CMP_LTU];
            default: br_taken = 1'b0;
        endcase
    end

    assign trap = (unit_i == UNIT_CSR) && (csr_op_i == ECALL || csr_op_i == EBREAK);

    assign redirect_o    = retire && (trap || kind_i == KIND_JUMP ||
                                      (kind_i == KIND_BRANCH && br_taken));
    assign redirect_pc_o = trap ? mtvec[31:1] : alu_result[31:1];

    assign unit_result = (unit_i == UNIT_CSR) ? csr_rdata : alu_result;
    assign fwd_data_o  = unit_result;

    // Writeback record
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_valid_o <= retire;
            wb_we_o    <= retire && we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (retire) begin
            wb_rd_o <= rd_i;
            case (wb_sel_i)
                WB_PC_PLUS: wb_data_o <= pc_plus_i;
                WB_MUL:     wb_data_o <= mul_result;
                default:    wb_data_o <= unit_result;
            endcase
        end
    end

    a_req_for_mul: assert property (@(posedge clk_i) disable iff (rst_i)
        mul_req_q |-> is_mul);

endmodule

/* testbench/tb_execute_stage.sv */
// Execute stage testbench
`timescale 1ns/1ps

module tb_execute_stage
    import rv_types_pkg::*;
    import exec_uop_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DLY   = 1;
    localparam int SAMPLE_DLY  = 20;
    localparam int MUL_TIMEOUT = 20;         // Cycles allowed for one multiply

    logic        clk_i;
    logic        rst_i;
    logic        valid_i;
    unit_e       unit_i;
    alu_op_e     alu_op_i;
    mul_op_e     mul_op_i;
    csr_op_e     csr_op_i;
    logic        csr_imm_i;
    br_cond_e    br_cond_i;
    instr_kind_e kind_i;
    wb_sel_e     wb_sel_i;
    logic        we_i;
    reg_addr_t   rd_i;
    xlen_t       pc_i;
    xlen_t       pc_plus_i;
    xlen_t       op_a_i;
    xlen_t       op_b_i;
    cmp_flags_t  cmp_flags_i;
    logic        stall_o;
    xlen_t       fwd_data_o;
    logic        redirect_o;
    pc_target_t  redirect_pc_o;
    logic        wb_valid_o;
    logic        wb_we_o;
    reg_addr_t   wb_rd_o;
    xlen_t       wb_data_o;

    int checks;
    int errors;
    int timeouts;

    execute_stage u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_target(input string name, input pc_target_t exp, input pc_target_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, act);
        end
    endtask

    // Reference ALU from the ISA definitions
    function automatic xlen_t alu_model(input alu_op_e op, input xlen_t a, input xlen_t b);
        logic [4:0] s;
        s = b[4:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << s;
            SLT:     return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            SLTU:    return {31'b0, a < b};
            XOR:     return a ^ b;
            SRL:     return a >> s;
            SRA:     return (a >> s) | (a[31] ? ~(32'hFFFF_FFFF >> s) : 32'h0);
            OR:      return a | b;
            AND:     return a & b;
            PASS_B:  return b;
            default: return 32'h0;
        endcase
    endfunction

    // 64-bit products taken modulo 2^64
    function automatic xlen_t mul_model(input mul_op_e op, input xlen_t a, input xlen_t b);
        logic [63:0] p;
        case (op)
            MULH:    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            MULHSU:  p = {{32{a[31]}}, a} * {32'h0, b};
            default: p = {32'h0, a} * {32'h0, b};     // MUL low word and MULHU
        endcase
        return (op == MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic branch_model(input br_cond_e cond, input cmp_flags_t f);
        case (cond)
            BEQ:     return f[0];
            BNE:     return !f[0];
            BLT:     return f[2];
            BGE:     return !f[2];
            BLTU:    return f[1];
            BGEU:    return !f[1];
            default: return 1'b0;
        endcase
    endfunction

    task automatic next_slot();
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic clear_inputs();
        valid_i     = 1'b0;
        unit_i      = UNIT_NONE;
        alu_op_i    = ADD;
        mul_op_i    = MUL;
        csr_op_i    = CSR_NONE;
        csr_imm_i   = 1'b0;
        br_cond_i   = BR_NONE;
        kind_i      = KIND_OTHER;
        wb_sel_i    = WB_RESULT;
        we_i        = 1'b0;
        rd_i        = '0;
        pc_i        = '0;
        pc_plus_i   = '0;
        op_a_i      = '0;
        op_b_i      = '0;
        cmp_flags_i = '0;
    endtask

    // Common fields of one instruction, rd is random
    task automatic present(input unit_e unit, input instr_kind_e kind, input wb_sel_e sel,
                           input logic we, input xlen_t a, input xlen_t b);
        valid_i     = 1'b1;
        unit_i      = unit;
        kind_i      = kind;
        wb_sel_i    = sel;
        we_i        = we;
        op_a_i      = a;
        op_b_i      = b;
        rd_i        = reg_addr_t'($urandom);
        alu_op_i    = ADD;
        csr_op_i    = CSR_NONE;
        csr_imm_i   = 1'b0;
        br_cond_i   = BR_NONE;
        cmp_flags_i = '0;
    endtask

    task automatic check_writeback(input logic we, input xlen_t data, input reg_addr_t rd);
        check_bit("wb_valid_o", 1'b1, wb_valid_o);
        check_bit("wb_we_o", we, wb_we_o);
        check_reg("wb_rd_o", rd, wb_rd_o);
        check_word("wb_data_o", data, wb_data_o);
    endtask

    task automatic test_reset();
        check_bit("wb_valid_o", 1'b0, wb_valid_o);
        check_bit("wb_we_o", 1'b0, wb_we_o);
        check_bit("redirect_o", 1'b0, redirect_o);
        check_bit("stall_o", 1'b0, stall_o);
    endtask

    task automatic test_alu();
        alu_op_e   op;
        xlen_t     a;
        xlen_t     b;
        xlen_t     exp;
        reg_addr_t rd;
        op = op.first();
        do begin
            a   = xlen_t'($urandom);
            b   = xlen_t'($urandom);
            exp = alu_model(op, a, b);
            present(UNIT_ALU, KIND_OTHER, WB_RESULT, 1'b1, a, b);
            alu_op_i = op;
            rd       = rd_i;
            #SAMPLE_DLY;
            check_word("fwd_data_o", exp, fwd_data_o);
            next_slot();
            check_writeback(1'b1, exp, rd);
            op = op.next();
        end while (op != op.first());
        a   = xlen_t'($urandom);
        b   = xlen_t'($urandom);
        exp = a + b;
        present(UNIT_ALU, KIND_JUMP, WB_PC_PLUS, 1'b1, a, b);   // JAL writes the link
        pc_i      = a;
        pc_plus_i = a + 32'd4;
        rd        = rd_i;
        #SAMPLE_DLY;
        check_bit("redirect_o", 1'b1, redirect_o);
        check_target("redirect_pc_o", exp[31:1], redirect_pc_o);
        next_slot();
        check_writeback(1'b1, a + 32'd4, rd);
        clear_inputs();
        next_slot();
    endtask

    task automatic test_branch();
        br_cond_e cond;
        xlen_t    a;
        xlen_t    b;
        xlen_t    sum;
        cond = cond.first();
        do begin
            for (int f = 0; f < 8; f++) begin
                a   = xlen_t'($urandom);
                b   = xlen_t'($urandom);
                sum = a + b;
                present(UNIT_ALU, KIND_BRANCH, WB_RESULT, 1'b0, a, b);
                br_cond_i   = cond;
                cmp_flags_i = cmp_flags_t'(f);
                #SAMPLE_DLY;
                check_bit("redirect_o", branch_model(cond, cmp_flags_t'(f)), redirect_o);
                check_target("redirect_pc_o", sum[31:1], redirect_pc_o);
                next_slot();
            end
            cond = cond.next();
        end while (cond != cond.first());
        for (int f = 0; f < 8; f++) begin
            a   = xlen_t'($urandom);
            b   = xlen_t'($urandom);
            sum = a + b;
            present(UNIT_ALU, KIND_JUMP, WB_PC_PLUS, 1'b0, a, b);  // Flags do not matter
            cmp_flags_i = cmp_flags_t'(f);
            #SAMPLE_DLY;
            check_bit("redirect_o", 1'b1, redirect_o);
            check_target("redirect_pc_o", sum[31:1], redirect_pc_o);
            next_slot();
        end
        clear_inputs();
        next_slot();
    endtask

    task automatic run_mul(input mul_op_e op, input xlen_t a, input xlen_t b);
        reg_addr_t rd;
        int        cycles;
        present(UNIT_MUL, KIND_OTHER, WB_MUL, 1'b1, a, b);
        mul_op_i = op;
        rd       = rd_i;
        #SAMPLE_DLY;
        check_bit("stall_o", 1'b1, stall_o);
        cycles = 0;
        while (stall_o && cycles < MUL_TIMEOUT) begin
            @(posedge clk_i);
            #SAMPLE_DLY;
            cycles++;
        end
        if (stall_o) begin
            timeouts++;
            $display("Timeout: %s still stalled after %0d cycles", op.name(), cycles);
        end
        next_slot();
        check_writeback(1'b1, mul_model(op, a, b), rd);
    endtask

    // Consecutive calls issue back-to-back multiplies
    task automatic test_mul();
        mul_op_e op;
        op = op.first();
        do begin
            run_mul(op, xlen_t'($urandom), xlen_t'($urandom));
            run_mul(op, 32'h8000_0000, 32'h8000_0000);
            run_mul(op, 32'hFFFF_FFF9, 32'h0000_0005);
            run_mul(op, 32'h0000_0007, 32'h8000_0000);
            op = op.next();
        end while (op != op.first());
        clear_inputs();
        next_slot();
    endtask

    task automatic run_csr(input csr_op_e op, input logic imm, input xlen_t rs1,
                           input logic [4:0] zimm, input csr_addr_t addr,
                           input xlen_t exp_old);
        reg_addr_t rd;
        present(UNIT_CSR, KIND_OTHER, WB_RESULT, 1'b1, rs1, {15'h0, zimm, addr});
        csr_op_i  = op;
        csr_imm_i = imm;
        rd        = rd_i;
        #SAMPLE_DLY;
        check_word("fwd_data_o", exp_old, fwd_data_o);
        next_slot();
        check_writeback(1'b1, exp_old, rd);
    endtask

    task automatic read_csr(input csr_addr_t addr, input xlen_t exp);
        run_csr(CSRRS, 1'b0, 32'h0, 5'h0, addr, exp);   // Set with zero leaves it unchanged
    endtask

    task automatic test_csr();
        xlen_t v;
        xlen_t shadow;
        v = xlen_t'($urandom);
        run_csr(CSRRW, 1'b0, v, 5'h0, CSR_MSCRATCH, 32'h0);
        read_csr(CSR_MSCRATCH, v);
        shadow = v;
        v = xlen_t'($urandom);
        run_csr(CSRRS, 1'b0, v, 5'h0, CSR_MSCRATCH, shadow);
        shadow = shadow | v;
        read_csr(CSR_MSCRATCH, shadow);
        v = xlen_t'($urandom);
        run_csr(CSRRC, 1'b0, v, 5'h0, CSR_MSCRATCH, shadow);
        shadow = shadow & ~v;
        read_csr(CSR_MSCRATCH, shadow);
        run_csr(CSRRS, 1'b1, 32'hFFFF_FFFF, 5'h15, CSR_MSCRATCH, shadow);  // rs1 unused
        shadow = shadow | 32'h15;
        read_csr(CSR_MSCRATCH, shadow);
        run_csr(CSRRC, 1'b1, 32'hFFFF_FFFF, 5'h0B, CSR_MSCRATCH, shadow);
        shadow = shadow & ~32'h0B;
        read_csr(CSR_MSCRATCH, shadow);
        run_csr(CSRRW, 1'b1, 32'hFFFF_FFFF, 5'h1F, CSR_MSCRATCH, shadow);
        read_csr(CSR_MSCRATCH, 32'h1F);
        run_csr(CSRRW, 1'b0, xlen_t'($urandom), 5'h0, 12'h7C0, 32'h0);  // Unknown address
        read_csr(12'h7C0, 32'h0);
        clear_inputs();
        next_slot();
    endtask

    task automatic run_trap(input csr_op_e op, input xlen_t pc, input xlen_t tvec);
        reg_addr_t rd;
        present(UNIT_CSR, KIND_OTHER, WB_RESULT, 1'b0, 32'h0, 32'h0);
        csr_op_i = op;
        pc_i     = pc;
        rd       = rd_i;
        #SAMPLE_DLY;
        check_bit("redirect_o", 1'b1, redirect_o);
        check_target("redirect_pc_o", tvec[31:1], redirect_pc_o);
        next_slot();
        check_writeback(1'b0, 32'h0, rd);        // Address zero reads as zero
    endtask

    task automatic test_trap();
        xlen_t tvec;
        xlen_t pc;
        tvec = xlen_t'($urandom) & 32'hFFFF_FFFC;
        run_csr(CSRRW, 1'b0, tvec, 5'h0, CSR_MTVEC, 32'h0);
        pc = xlen_t'($urandom) & 32'hFFFF_FFFC;
        run_trap(ECALL, pc, tvec);
        read_csr(CSR_MEPC, pc);
        read_csr(CSR_MCAUSE, 32'd11);             // Environment call from M-mode
        pc = xlen_t'($urandom) & 32'hFFFF_FFFC;
        run_trap(EBREAK, pc, tvec);
        read_csr(CSR_MEPC, pc);
        read_csr(CSR_MCAUSE, 32'd3);              // Breakpoint
        clear_inputs();
        next_slot();
    endtask

    initial begin
        void'($urandom(33));
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        clear_inputs();
        rst_i = 1'b1;
        repeat (4) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;
        test_reset();
        test_alu();
        test_branch();
        test_mul();
        test_csr();
        test_trap();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* execute_stage.f */
src/rv_types_pkg.sv
src/exec_uop_pkg.sv
src/alu.sv
src/mul_unit.sv
src/csr_unit.sv
src/execute_stage.sv
testbench/tb_execute_stage.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= execute_stage.f
TB_TOP    ?= tb_execute_stage
RTL_TOP   ?= execute_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= TESTS FAILED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
